/* design/axi_xbar_pkg.sv */
/*
 * Shared widths, channel payload structs and the default address map of
 * the two-initiator, two-target AXI interconnect. Referenced by scoped name.
 */
`default_nettype none

package axi_xbar_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	localparam int STRB_W = DATA_W / 8;
	localparam int ID_W = 4;
	localparam int LEN_W = 8;

	// AW and AR share one request layout
	typedef struct packed {
		logic [ID_W-1:0] id;
		logic [ADDR_W-1:0] addr;
		logic [LEN_W-1:0] len;
	} addr_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
		logic last;
	} w_beat_t;

	typedef struct packed {
		logic [ID_W-1:0] id;
		logic [1:0] resp;
	} b_resp_t;

	typedef struct packed {
		logic [ID_W-1:0] id;
		logic [DATA_W-1:0] data;
		logic [1:0] resp;
		logic last;
	} r_beat_t;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	// index 0 is main memory, index 1 the timer
	localparam int N_TARGETS = 2;
	localparam logic [N_TARGETS-1:0][ADDR_W-1:0] DEF_BASE = {32'h8000_0000, 32'h0000_0000};
	localparam logic [N_TARGETS-1:0][ADDR_W-1:0] DEF_SIZE = {32'h8000_0000, 32'h8000_0000};

endpackage

`default_nettype wire

/* design/xbar_req_if.sv */
/*
 * Arbitrated request bundle, broadcast from the arbiter to every target port.
 * The master-side readies come back on it from the response mux.
 */
`timescale 1ns/1ps
`default_nettype none

interface xbar_req_if (
	input logic clk,
	input logic rst_n
);

	logic aw_valid;
	logic aw_ready;
	axi_xbar_pkg::addr_req_t aw;
	logic w_valid;
	logic w_ready;
	axi_xbar_pkg::w_beat_t w;
	logic ar_valid;
	logic ar_ready;
	axi_xbar_pkg::addr_req_t ar;
	logic b_ready;
	logic r_ready;

	modport arb (
		output aw_valid, aw, w_valid, w, ar_valid, ar, b_ready, r_ready,
		input aw_ready, w_ready, ar_ready
	);

	// clock comes along for the checks in the mux
	modport mux (
		input clk, rst_n, aw_valid, ar_valid,
		output aw_ready, w_ready, ar_ready
	);

	modport port (
		input aw_valid, aw, w_valid, w, ar_valid, ar, b_ready, r_ready
	);

endinterface

`default_nettype wire

/* design/axi_target_if.sv */
/*
 * Channels of one target plus the decode and selection flags of its port.
 * Instantiated once per target as an array in the top level.
 */
`timescale 1ns/1ps
`default_nettype none

interface axi_target_if;

	logic aw_valid;
	logic aw_ready;
	axi_xbar_pkg::addr_req_t aw;
	logic w_valid;
	logic w_ready;
	axi_xbar_pkg::w_beat_t w;
	logic b_valid;
	logic b_ready;
	axi_xbar_pkg::b_resp_t b;
	logic ar_valid;
	logic ar_ready;
	axi_xbar_pkg::addr_req_t ar;
	logic r_valid;
	logic r_ready;
	axi_xbar_pkg::r_beat_t r;

	// window hits and owning-transfer flags
	logic hit_aw;
	logic hit_ar;
	logic sel_w;
	logic sel_r;

	modport port (
		output aw_valid, aw, w_valid, w, b_ready, ar_valid, ar, r_ready,
		output hit_aw, hit_ar, sel_w, sel_r,
		input aw_ready, w_ready, b_valid, b, ar_ready, r_valid, r
	);

	modport ext (
		input aw_valid, aw, w_valid, w, b_ready, ar_valid, ar, r_ready,
		output aw_ready, w_ready, b_valid, b, ar_ready, r_valid, r
	);

	modport mux (
		input aw_ready, w_ready, b_valid, b, ar_ready, r_valid, r,
		input hit_aw, hit_ar, sel_w, sel_r
	);

endinterface

`default_nettype wire

/* design/txn_arbiter.sv */
/*
 * Master side of the interconnect. Tracks one write and one read in flight,
 * picks the data master over the fetch master for new reads and returns
 * B and R to the master that owns the transfer.
 */
`timescale 1ns/1ps
`default_nettype none

module txn_arbiter (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic f_ar_valid,
	input axi_xbar_pkg::addr_req_t f_ar,
	output logic f_ar_ready,
	output logic f_r_valid,
	output axi_xbar_pkg::r_beat_t f_r,
	input wire logic f_r_ready,

	input wire logic d_aw_valid,
	input axi_xbar_pkg::addr_req_t d_aw,
	output logic d_aw_ready,
	input wire logic d_w_valid,
	input axi_xbar_pkg::w_beat_t d_w,
	output logic d_w_ready,
	output logic d_b_valid,
	output axi_xbar_pkg::b_resp_t d_b,
	input wire logic d_b_ready,
	input wire logic d_ar_valid,
	input axi_xbar_pkg::addr_req_t d_ar,
	output logic d_ar_ready,
	output logic d_r_valid,
	output axi_xbar_pkg::r_beat_t d_r,
	input wire logic d_r_ready,

	xbar_req_if.arb req,

	input wire logic b_valid,
	input axi_xbar_pkg::b_resp_t b,
	input wire logic r_valid,
	input axi_xbar_pkg::r_beat_t r
);

	logic live;
	logic w_busy;
	logic r_busy;
	logic r_owner_d;
	logic w_idle;
	logic r_idle;
	logic ar_sel_d;

	// nothing is accepted in the first cycle out of reset
	assign w_idle = live && !w_busy;
	assign r_idle = live && !r_busy;
	assign ar_sel_d = d_ar_valid;

	assign req.aw_valid = d_aw_valid && w_idle;
	assign req.aw = d_aw;
	assign d_aw_ready = req.aw_ready && w_idle;

	assign req.w_valid = d_w_valid && w_busy;
	assign req.w = d_w;
	assign d_w_ready = req.w_ready && w_busy;

	assign d_b_valid = b_valid && w_busy;
	assign d_b = b;
	assign req.b_ready = d_b_ready && w_busy;

	// data master wins
	assign req.ar_valid = r_idle && (d_ar_valid || f_ar_valid);
	assign req.ar = ar_sel_d ? d_ar : f_ar;
	assign d_ar_ready = req.ar_ready && r_idle && ar_sel_d;
	assign f_ar_ready = req.ar_ready && r_idle && !ar_sel_d;

	assign d_r_valid = r_valid && r_busy && r_owner_d;
	assign f_r_valid = r_valid && r_busy && !r_owner_d;
	assign d_r = r;
	assign f_r = r;
	assign req.r_ready = r_busy && (r_owner_d ? d_r_ready : f_r_ready);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			live <= 1'b0;
			w_busy <= 1'b0;
			r_busy <= 1'b0;
			r_owner_d <= 1'b0;
		end else begin
			live <= 1'b1;
			if (req.aw_valid && req.aw_ready) begin
				w_busy <= 1'b1;
			end else if (d_b_valid && d_b_ready) begin
				w_busy <= 1'b0;
			end
			if (req.ar_valid && req.ar_ready) begin
				r_busy <= 1'b1;
				r_owner_d <= ar_sel_d;
			end else if (r_valid && req.r_ready && r.last) begin
				r_busy <= 1'b0;
			end
		end
	end

	// selected target's B only while the write is open
	a_b_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
		b_valid |-> w_busy);

endmodule

`default_nettype wire

/* design/target_port.sv */
/*
 * Per-target slice of the interconnect. Decodes the request address against
 * this target's window, forwards it relative to BASE on a hit and keeps the
 * flags that tie W, B and R to this target while a transfer is open.
 */
`timescale 1ns/1ps
`default_nettype none

module target_port #(
	parameter logic [axi_xbar_pkg::ADDR_W-1:0] BASE = '0,
	parameter logic [axi_xbar_pkg::ADDR_W-1:0] SIZE = axi_xbar_pkg::DEF_SIZE[0]
) (
	input wire logic clk,
	input wire logic rst_n,
	xbar_req_if.port req,
	axi_target_if.port tgt
);

	logic [axi_xbar_pkg::ADDR_W-1:0] aw_off;
	logic [axi_xbar_pkg::ADDR_W-1:0] ar_off;
	logic hit_aw;
	logic hit_ar;
	logic sel_w;
	logic sel_r;

	// offset compare avoids overflow at the top of the map
	assign aw_off = req.aw.addr - BASE;
	assign ar_off = req.ar.addr - BASE;
	assign hit_aw = aw_off < SIZE;
	assign hit_ar = ar_off < SIZE;

	assign tgt.aw_valid = req.aw_valid && hit_aw;
	assign tgt.ar_valid = req.ar_valid && hit_ar;

	always_comb begin
		tgt.aw = req.aw;
		tgt.aw.addr = aw_off;
		tgt.ar = req.ar;
		tgt.ar.addr = ar_off;
	end

	assign tgt.w_valid = req.w_valid && sel_w;
	assign tgt.w = req.w;
	assign tgt.b_ready = req.b_ready && sel_w;
	assign tgt.r_ready = req.r_ready && sel_r;

	assign tgt.hit_aw = hit_aw;
	assign tgt.hit_ar = hit_ar;
	assign tgt.sel_w = sel_w;
	assign tgt.sel_r = sel_r;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sel_w <= 1'b0;
			sel_r <= 1'b0;
		end else begin
			if (tgt.aw_valid && tgt.aw_ready) begin
				sel_w <= 1'b1;
			end else if (tgt.b_valid && tgt.b_ready) begin
				sel_w <= 1'b0;
			end
			if (tgt.ar_valid && tgt.ar_ready) begin
				sel_r <= 1'b1;
			end else if (tgt.r_valid && tgt.r_ready && tgt.r.last) begin
				sel_r <= 1'b0;
			end
		end
	end

	// arbiter must hold off new reads until the last beat is gone
	a_sel_r_no_reload: assert property (@(posedge clk) disable iff (!rst_n)
		tgt.ar_valid && tgt.ar_ready |-> !sel_r);

endmodule

`default_nettype wire

/* design/resp_mux.sv */
/*
 * Combinational return path. Picks the request readies of the target that
 * decodes the address and the W ready, B and R of the selected target.
 */
`timescale 1ns/1ps
`default_nettype none

module resp_mux #(
	parameter int N_TARGETS = axi_xbar_pkg::N_TARGETS
) (
	xbar_req_if.mux req,
	axi_target_if.mux tgts [N_TARGETS],
	output logic b_valid,
	output axi_xbar_pkg::b_resp_t b,
	output logic r_valid,
	output axi_xbar_pkg::r_beat_t r
);

	logic [N_TARGETS-1:0] aw_rdy;
	logic [N_TARGETS-1:0] w_rdy;
	logic [N_TARGETS-1:0] ar_rdy;
	logic [N_TARGETS-1:0] b_vld;
	logic [N_TARGETS-1:0] r_vld;
	logic [N_TARGETS-1:0] hit_aw;
	logic [N_TARGETS-1:0] hit_ar;
	logic [N_TARGETS-1:0] sel_w;
	logic [N_TARGETS-1:0] sel_r;
	axi_xbar_pkg::b_resp_t b_pl [N_TARGETS];
	axi_xbar_pkg::r_beat_t r_pl [N_TARGETS];

	// flatten the interface array so it can be walked in a loop
	for (genvar i = 0; i < N_TARGETS; i++) begin : g_gather
		assign aw_rdy[i] = tgts[i].aw_ready;
		assign w_rdy[i] = tgts[i].w_ready;
		assign ar_rdy[i] = tgts[i].ar_ready;
		assign b_vld[i] = tgts[i].b_valid;
		assign r_vld[i] = tgts[i].r_valid;
		assign hit_aw[i] = tgts[i].hit_aw;
		assign hit_ar[i] = tgts[i].hit_ar;
		assign sel_w[i] = tgts[i].sel_w;
		assign sel_r[i] = tgts[i].sel_r;
		assign b_pl[i] = tgts[i].b;
		assign r_pl[i] = tgts[i].r;
	end

	always_comb begin
		req.aw_ready = 1'b0;
		req.w_ready = 1'b0;
		req.ar_ready = 1'b0;
		b_valid = 1'b0;
		b = '0;
		r_valid = 1'b0;
		r = '0;
		for (int i = 0; i < N_TARGETS; i++) begin
			if (hit_aw[i]) begin
				req.aw_ready = aw_rdy[i];
			end
			if (hit_ar[i]) begin
				req.ar_ready = ar_rdy[i];
			end
			if (sel_w[i]) begin
				req.w_ready = w_rdy[i];
				b_valid = b_vld[i];
				b = b_pl[i];
			end
			if (sel_r[i]) begin
				r_valid = r_vld[i];
				r = r_pl[i];
			end
		end
	end

	// windows must tile the address space
	a_one_aw_hit: assert property (@(posedge req.clk) disable iff (!req.rst_n)
		req.aw_valid |-> $onehot(hit_aw));
	a_one_ar_hit: assert property (@(posedge req.clk) disable iff (!req.rst_n)
		req.ar_valid |-> $onehot(hit_ar));

endmodule

`default_nettype wire

/* design/axi_xbar_top.sv */
/*
 * AXI interconnect top level. Fetch and data masters on one side, main
 * memory (m_) and timer (t_) targets on the other, all as plain ports.
 */
`timescale 1ns/1ps
`default_nettype none

module axi_xbar_top #(
	parameter int N_TARGETS = axi_xbar_pkg::N_TARGETS,
	parameter logic [N_TARGETS-1:0][axi_xbar_pkg::ADDR_W-1:0] TARGET_BASE =
		axi_xbar_pkg::DEF_BASE,
	parameter logic [N_TARGETS-1:0][axi_xbar_pkg::ADDR_W-1:0] TARGET_SIZE =
		axi_xbar_pkg::DEF_SIZE
) (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic f_ar_valid,
	input axi_xbar_pkg::addr_req_t f_ar,
	output logic f_ar_ready,
	output logic f_r_valid,
	output axi_xbar_pkg::r_beat_t f_r,
	input wire logic f_r_ready,

	input wire logic d_aw_valid,
	input axi_xbar_pkg::addr_req_t d_aw,
	output logic d_aw_ready,
	input wire logic d_w_valid,
	input axi_xbar_pkg::w_beat_t d_w,
	output logic d_w_ready,
	output logic d_b_valid,
	output axi_xbar_pkg::b_resp_t d_b,
	input wire logic d_b_ready,
	input wire logic d_ar_valid,
	input axi_xbar_pkg::addr_req_t d_ar,
	output logic d_ar_ready,
	output logic d_r_valid,
	output axi_xbar_pkg::r_beat_t d_r,
	input wire logic d_r_ready,

	output logic m_aw_valid,
	output axi_xbar_pkg::addr_req_t m_aw,
	input wire logic m_aw_ready,
	output logic m_w_valid,
	output axi_xbar_pkg::w_beat_t m_w,
	input wire logic m_w_ready,
	input wire logic m_b_valid,
	input axi_xbar_pkg::b_resp_t m_b,
	output logic m_b_ready,
	output logic m_ar_valid,
	output axi_xbar_pkg::addr_req_t m_ar,
	input wire logic m_ar_ready,
	input wire logic m_r_valid,
	input axi_xbar_pkg::r_beat_t m_r,
	output logic m_r_ready,

	output logic t_aw_valid,
	output axi_xbar_pkg::addr_req_t t_aw,
	input wire logic t_aw_ready,
	output logic t_w_valid,
	output axi_xbar_pkg::w_beat_t t_w,
	input wire logic t_w_ready,
	input wire logic t_b_valid,
	input axi_xbar_pkg::b_resp_t t_b,
	output logic t_b_ready,
	output logic t_ar_valid,
	output axi_xbar_pkg::addr_req_t t_ar,
	input wire logic t_ar_ready,
	input wire logic t_r_valid,
	input axi_xbar_pkg::r_beat_t t_r,
	output logic t_r_ready
);

	logic b_valid;
	axi_xbar_pkg::b_resp_t b;
	logic r_valid;
	axi_xbar_pkg::r_beat_t r;

	xbar_req_if req_if (.clk(clk), .rst_n(rst_n));
	axi_target_if tgt_if [N_TARGETS] ();

	txn_arbiter u_txn_arbiter (
		.clk(clk), .rst_n(rst_n),
		.f_ar_valid(f_ar_valid), .f_ar(f_ar), .f_ar_ready(f_ar_ready),
		.f_r_valid(f_r_valid), .f_r(f_r), .f_r_ready(f_r_ready),
		.d_aw_valid(d_aw_valid), .d_aw(d_aw), .d_aw_ready(d_aw_ready),
		.d_w_valid(d_w_valid), .d_w(d_w), .d_w_ready(d_w_ready),
		.d_b_valid(d_b_valid), .d_b(d_b), .d_b_ready(d_b_ready),
		.d_ar_valid(d_ar_valid), .d_ar(d_ar), .d_ar_ready(d_ar_ready),
		.d_r_valid(d_r_valid), .d_r(d_r), .d_r_ready(d_r_ready),
		.req(req_if),
		.b_valid(b_valid), .b(b), .r_valid(r_valid), .r(r)
	);

	for (genvar i = 0; i < N_TARGETS; i++) begin : g_port
		target_port #(
			.BASE(TARGET_BASE[i]),
			.SIZE(TARGET_SIZE[i])
		) u_target_port (
			.clk(clk),
			.rst_n(rst_n),
			.req(req_if),
			.tgt(tgt_if[i])
		);
	end

	resp_mux #(.N_TARGETS(N_TARGETS)) u_resp_mux (
		.req(req_if), .tgts(tgt_if),
		.b_valid(b_valid), .b(b), .r_valid(r_valid), .r(r)
	);

	// main memory
	assign m_aw_valid = tgt_if[0].aw_valid;
	assign m_aw = tgt_if[0].aw;
	assign tgt_if[0].aw_ready = m_aw_ready;
	assign m_w_valid = tgt_if[0].w_valid;
	assign m_w = tgt_if[0].w;
	assign tgt_if[0].w_ready = m_w_ready;
	assign tgt_if[0].b_valid = m_b_valid;
	assign tgt_if[0].b = m_b;
	assign m_b_ready = tgt_if[0].b_ready;
	assign m_ar_valid = tgt_if[0].ar_valid;
	assign m_ar = tgt_if[0].ar;
	assign tgt_if[0].ar_ready = m_ar_ready;
	assign tgt_if[0].r_valid = m_r_valid;
	assign tgt_if[0].r = m_r;
	assign m_r_ready = tgt_if[0].r_ready;

	// timer
	assign t_aw_valid = tgt_if[1].aw_valid;
	assign t_aw = tgt_if[1].aw;
	assign tgt_if[1].aw_ready = t_aw_ready;
	assign t_w_valid = tgt_if[1].w_valid;
	assign t_w = tgt_if[1].w;
	assign tgt_if[1].w_ready = t_w_ready;
	assign tgt_if[1].b_valid = t_b_valid;
	assign tgt_if[1].b = t_b;
	assign t_b_ready = tgt_if[1].b_ready;
	assign t_ar_valid = tgt_if[1].ar_valid;
	assign t_ar = tgt_if[1].ar;
	assign tgt_if[1].ar_ready = t_ar_ready;
	assign tgt_if[1].r_valid = t_r_valid;
	assign tgt_if[1].r = t_r;
	assign t_r_ready = tgt_if[1].r_ready;

endmodule

`default_nettype wire

/* verif/target_model.sv */
/*
 * Behavioral AXI target for the interconnect testbench. Holds 16 64-bit
 * words seeded with TAG and the word index, with random ready and valid delays.
 */
`timescale 1ns/1ps
`default_nettype none

module target_model #(
	parameter logic [31:0] TAG = 32'h0000_00a0
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic aw_valid,
	input axi_xbar_pkg::addr_req_t aw,
	output logic aw_ready,
	input wire logic w_valid,
	input axi_xbar_pkg::w_beat_t w,
	output logic w_ready,
	output logic b_valid,
	output axi_xbar_pkg::b_resp_t b,
	input wire logic b_ready,
	input wire logic ar_valid,
	input axi_xbar_pkg::addr_req_t ar,
	output logic ar_ready,
	output logic r_valid,
	output axi_xbar_pkg::r_beat_t r,
	input wire logic r_ready
);

	logic [63:0] mem [16];
	integer seed = 6795;
	logic w_act;
	logic b_pend;
	logic [3:0] w_idx;
	logic [3:0] w_id;
	logic r_act;
	logic [3:0] r_idx;
	logic [7:0] r_cnt;
	logic [3:0] r_id;

	always_comb begin
		b.id = w_id;
		b.resp = axi_xbar_pkg::RESP_OKAY;
		r.id = r_id;
		r.data = mem[r_idx];
		r.resp = axi_xbar_pkg::RESP_OKAY;
		r.last = (r_cnt == 8'd0);
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int k = 0; k < 16; k++) begin
				mem[k] <= {TAG, 32'(k)};
			end
			{aw_ready, w_ready, b_valid, ar_ready, r_valid} <= '0;
			{w_act, b_pend, r_act} <= '0;
			{w_idx, w_id, r_idx, r_cnt, r_id} <= '0;
		end else begin
			// write address, then beats, then response
			if (aw_valid && aw_ready) begin
				aw_ready <= 1'b0;
				w_act <= 1'b1;
				w_idx <= aw.addr[6:3];
				w_id <= aw.id;
			end else if (!w_act && !b_pend && !aw_ready) begin
				aw_ready <= (($random(seed) & 3) != 0);
			end
			if (w_valid && w_ready) begin
				for (int i = 0; i < 8; i++) begin
					if (w.strb[i]) begin
						mem[w_idx][8*i +: 8] <= w.data[8*i +: 8];
					end
				end
				w_idx <= w_idx + 4'd1;
				if (w.last) begin
					w_act <= 1'b0;
					b_pend <= 1'b1;
				end
				w_ready <= !w.last && (($random(seed) & 3) != 0);
			end else begin
				w_ready <= w_act && (($random(seed) & 3) != 0);
			end
			if (b_valid && b_ready) begin
				b_valid <= 1'b0;
				b_pend <= 1'b0;
			end else if (b_pend && !b_valid) begin
				b_valid <= (($random(seed) & 1) != 0);
			end
			// read address, then beats
			if (ar_valid && ar_ready) begin
				ar_ready <= 1'b0;
				r_act <= 1'b1;
				r_idx <= ar.addr[6:3];
				r_cnt <= ar.len;
				r_id <= ar.id;
			end else if (!r_act && !ar_ready) begin
				ar_ready <= (($random(seed) & 3) != 0);
			end
			if (r_valid && r_ready) begin
				r_valid <= 1'b0;
				r_idx <= r_idx + 4'd1;
				r_cnt <= r_cnt - 8'd1;
				if (r_cnt == 8'd0) begin
					r_act <= 1'b0;
				end
			end else if (r_act && !r_valid) begin
				r_valid <= (($random(seed) & 3) != 0);
			end
		end
	end

endmodule

`default_nettype wire

/* verif/tb_axi_xbar.sv */
/*
 * Testbench for the AXI interconnect. Drives the fetch and data masters,
 * keeps a shadow of both target memories and checks every R beat and B.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_xbar;

	localparam int N_TXN = 45;
	localparam int LIMIT = N_TXN * 64;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic f_ar_valid, f_ar_ready, f_r_valid, f_r_ready;
	axi_xbar_pkg::addr_req_t f_ar;
	axi_xbar_pkg::r_beat_t f_r;
	logic d_aw_valid, d_aw_ready, d_w_valid, d_w_ready, d_b_valid, d_b_ready;
	logic d_ar_valid, d_ar_ready, d_r_valid, d_r_ready;
	axi_xbar_pkg::addr_req_t d_aw, d_ar;
	axi_xbar_pkg::w_beat_t d_w;
	axi_xbar_pkg::b_resp_t d_b;
	axi_xbar_pkg::r_beat_t d_r;
	logic m_aw_valid, m_aw_ready, m_w_valid, m_w_ready, m_b_valid, m_b_ready;
	logic m_ar_valid, m_ar_ready, m_r_valid, m_r_ready;
	axi_xbar_pkg::addr_req_t m_aw, m_ar;
	axi_xbar_pkg::w_beat_t m_w;
	axi_xbar_pkg::b_resp_t m_b;
	axi_xbar_pkg::r_beat_t m_r;
	logic t_aw_valid, t_aw_ready, t_w_valid, t_w_ready, t_b_valid, t_b_ready;
	logic t_ar_valid, t_ar_ready, t_r_valid, t_r_ready;
	axi_xbar_pkg::addr_req_t t_aw, t_ar;
	axi_xbar_pkg::w_beat_t t_w;
	axi_xbar_pkg::b_resp_t t_b;
	axi_xbar_pkg::r_beat_t t_r;

	integer seed = 6795;
	int errors = 0;
	int cycles = 0;
	logic rand_rdy = 1'b0;
	logic rst_q = 1'b0;
	logic rd_out = 1'b0;
	logic [63:0] shadow [2][16];
	axi_xbar_pkg::r_beat_t d_exp_q[$];
	axi_xbar_pkg::r_beat_t f_exp_q[$];
	axi_xbar_pkg::b_resp_t b_exp_q[$];

	always #5 clk = ~clk;

	axi_xbar_top u_axi_xbar_top (.*);

	target_model #(.TAG(32'h0000_00a0)) u_mem (
		.clk(clk), .rst_n(rst_n),
		.aw_valid(m_aw_valid), .aw(m_aw), .aw_ready(m_aw_ready),
		.w_valid(m_w_valid), .w(m_w), .w_ready(m_w_ready),
		.b_valid(m_b_valid), .b(m_b), .b_ready(m_b_ready),
		.ar_valid(m_ar_valid), .ar(m_ar), .ar_ready(m_ar_ready),
		.r_valid(m_r_valid), .r(m_r), .r_ready(m_r_ready)
	);

	target_model #(.TAG(32'h0000_00b0)) u_timer (
		.clk(clk), .rst_n(rst_n),
		.aw_valid(t_aw_valid), .aw(t_aw), .aw_ready(t_aw_ready),
		.w_valid(t_w_valid), .w(t_w), .w_ready(t_w_ready),
		.b_valid(t_b_valid), .b(t_b), .b_ready(t_b_ready),
		.ar_valid(t_ar_valid), .ar(t_ar), .ar_ready(t_ar_ready),
		.r_valid(t_r_valid), .r(t_r), .r_ready(t_r_ready)
	);

	// window from the top address bit, word from the offset in the window
	function automatic logic [63:0] ref_word(input logic [31:0] addr);
		logic [31:0] off;
		off = addr - (addr[31] ? 32'h8000_0000 : 32'h0);
		return shadow[addr[31]][off[6:3]];
	endfunction

	task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
		if (exp !== act) begin
			$display("Mismatch %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic issue_read(input logic fetch, input logic [31:0] addr, input logic [7:0] len,
			input logic [3:0] id);
		axi_xbar_pkg::r_beat_t beat;
		for (int i = 0; i <= len; i++) begin
			beat.id = id;
			beat.data = ref_word(addr + 32'(8 * i));
			beat.resp = axi_xbar_pkg::RESP_OKAY;
			beat.last = (i == len);
			if (fetch) f_exp_q.push_back(beat);
			else d_exp_q.push_back(beat);
		end
		@(posedge clk);
		if (fetch) begin
			f_ar_valid <= 1'b1;
			f_ar <= '{id: id, addr: addr, len: len};
			do @(posedge clk); while (!f_ar_ready);
			f_ar_valid <= 1'b0;
			while (!(f_r_valid && f_r_ready && f_r.last)) @(posedge clk);
		end else begin
			d_ar_valid <= 1'b1;
			d_ar <= '{id: id, addr: addr, len: len};
			do @(posedge clk); while (!d_ar_ready);
			d_ar_valid <= 1'b0;
			while (!(d_r_valid && d_r_ready && d_r.last)) @(posedge clk);
		end
	endtask

	task automatic issue_write(input logic [31:0] addr, input logic [7:0] len,
			input logic [3:0] id, input logic [7:0] strb);
		logic [63:0] data [16];
		logic [31:0] off;
		off = addr - (addr[31] ? 32'h8000_0000 : 32'h0);
		for (int i = 0; i <= len; i++) begin
			data[i] = {$random(seed), $random(seed)};
			for (int j = 0; j < 8; j++) begin
				if (strb[j]) shadow[addr[31]][4'(off[6:3] + i)][8*j +: 8] = data[i][8*j +: 8];
			end
		end
		b_exp_q.push_back('{id: id, resp: axi_xbar_pkg::RESP_OKAY});
		@(posedge clk);
		d_aw_valid <= 1'b1;
		d_aw <= '{id: id, addr: addr, len: len};
		do @(posedge clk); while (!d_aw_ready);
		d_aw_valid <= 1'b0;
		for (int i = 0; i <= len; i++) begin
			d_w_valid <= 1'b1;
			d_w <= '{data: data[i], strb: strb, last: (i == len)};
			do @(posedge clk); while (!d_w_ready);
		end
		d_w_valid <= 1'b0;
		while (!(d_b_valid && d_b_ready)) @(posedge clk);
	endtask

	always @(posedge clk) begin
		d_r_ready <= rand_rdy ? (($random(seed) & 3) != 0) : 1'b1;
		f_r_ready <= rand_rdy ? (($random(seed) & 1) != 0) : 1'b1;
	end

	// comparison process
	always @(posedge clk) begin
		cycles <= cycles + 1;
		rst_q <= rst_n;
		// registers hold their reset values from the second edge on
		if (cycles != 0 && (!rst_n || !rst_q)) begin
			check("reset", '0, {m_aw_valid, m_w_valid, m_ar_valid, t_aw_valid, t_w_valid,
				t_ar_valid, f_ar_ready, d_aw_ready, d_w_ready, d_ar_ready});
		end
		if (rd_out) begin
			check("ar ready while read busy", '0, {f_ar_ready, d_ar_ready});
		end
		if ((d_ar_valid && d_ar_ready) || (f_ar_valid && f_ar_ready)) rd_out <= 1'b1;
		if (d_r_valid && d_r_ready) begin
			if (d_exp_q.size() == 0) begin
				$display("data master got an R beat with no read outstanding");
				errors++;
			end else begin
				check("data read", d_exp_q.pop_front(), d_r);
			end
			if (d_r.last) rd_out <= 1'b0;
		end
		if (f_r_valid && f_r_ready) begin
			if (f_exp_q.size() == 0) begin
				$display("fetch master got an R beat with no read outstanding");
				errors++;
			end else begin
				check("fetch read", f_exp_q.pop_front(), f_r);
			end
			if (f_r.last) rd_out <= 1'b0;
		end
		if (d_b_valid && d_b_ready) begin
			if (b_exp_q.size() == 0) begin
				$display("write response arrived with no write outstanding");
				errors++;
			end else begin
				check("write resp", b_exp_q.pop_front(), d_b);
			end
		end
		if (cycles >= LIMIT) begin
			$display("timeout after %0d cycles, errors: %0d", cycles, errors);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		logic [31:0] a;
		logic [31:0] b_addr;
		logic [7:0] l;
		logic [7:0] l2;
		// requests held up across reset must not reach a target
		f_ar_valid = 1'b1;
		f_ar = '0;
		d_aw_valid = 1'b1;
		d_aw = '0;
		d_w_valid = 1'b1;
		d_w = '0;
		d_b_ready = 1'b1;
		d_ar_valid = 1'b1;
		d_ar = '0;
		d_r_ready = 1'b1;
		f_r_ready = 1'b1;
		for (int k = 0; k < 16; k++) begin
			shadow[0][k] = {32'h0000_00a0, 32'(k)};
			shadow[1][k] = {32'h0000_00b0, 32'(k)};
		end
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		f_ar_valid <= 1'b0;
		d_aw_valid <= 1'b0;
		d_w_valid <= 1'b0;
		d_ar_valid <= 1'b0;
		repeat (2) @(posedge clk);
		// untouched words show tag and index
		for (int k = 4; k < 8; k++) begin
			issue_read(1'b0, 32'h8000_0000 + 32'(8 * k), 8'd0, 4'd1);
			issue_read(1'b1, 32'(8 * k), 8'd0, 4'd2);
		end
		issue_write(32'h0000_0010, 8'd0, 4'd3, 8'h0f);
		issue_write(32'h8000_0018, 8'd0, 4'd4, 8'hf0);
		issue_read(1'b0, 32'h0000_0010, 8'd0, 4'd5);
		issue_read(1'b0, 32'h8000_0018, 8'd0, 4'd6);
		// bursts
		issue_read(1'b0, 32'h0000_0020, 8'd3, 4'd7);
		issue_write(32'h8000_0040, 8'd3, 4'd8, 8'h5a);
		issue_read(1'b1, 32'h8000_0040, 8'd3, 4'd9);
		for (int n = 0; n < 3; n++) begin
			fork
				issue_read(1'b0, 32'h8000_0008 + 32'(16 * n), 8'd1, 4'd5);
				issue_read(1'b1, 32'h0000_0030 + 32'(8 * n), 8'd2, 4'd9);
			join
		end
		// random back-pressure on both masters
		rand_rdy = 1'b1;
		for (int n = 0; n < 10; n++) begin
			a = {$random(seed)} & 32'h8000_0078;
			b_addr = {$random(seed)} & 32'h8000_0078;
			l = 8'({$random(seed)} & 3);
			l2 = 8'({$random(seed)} & 3);
			if (n % 3 == 0) issue_write(a, l, 4'(n), 8'({$random(seed)} | 1));
			fork
				issue_read(1'b0, a, l, 4'(n));
				issue_read(1'b1, b_addr, l2, 4'(n + 1));
			join
		end
		repeat (5) @(posedge clk);
		if (d_exp_q.size() != 0 || f_exp_q.size() != 0 || b_exp_q.size() != 0) begin
			$display("responses still missing at the end of the run");
			errors++;
		end
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
design/axi_xbar_pkg.sv
design/xbar_req_if.sv
design/axi_target_if.sv
design/txn_arbiter.sv
design/target_port.sv
design/resp_mux.sv
design/axi_xbar_top.sv
verif/target_model.sv
verif/tb_axi_xbar.sv

/* Makefile */
# Verilator build and run of the AXI interconnect testbench

VERILATOR ?= verilator
TOP ?= tb_axi_xbar
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
